/* verilog/grid_pkg.sv */
`default_nettype none

package grid_pkg;

    // --------------------
    // Grid geometry

    // Cells per side of the square drawing area
    localparam int GRID_SIZE = 28;

    localparam int GRID_CELLS = GRID_SIZE * GRID_SIZE;

    // Column or row index, 0 to GRID_SIZE-1
    typedef logic [4:0] coord_t;

    // Row-major cell index, row * GRID_SIZE + column
    typedef logic [9:0] cell_addr_t;

    // --------------------
    // Cursor behaviour

    // Cursor home on both axes
    localparam coord_t START_COORD = 5'd14;

    // Hold-off after a move, about 40 ms at 50 MHz
    localparam int MOVE_DELAY_DEFAULT = 2_000_000;

    typedef logic [20:0] delay_t;

endpackage

`default_nettype wire

/* verilog/ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

    typedef logic [7:0] scan_code_t;

    // Start bit, eight data bits, parity, stop bit
    localparam int FRAME_BITS = 11;

    // Samples of the PS/2 clock that must agree before the level changes
    localparam int FILTER_DEPTH = 8;

    // --------------------
    // Arrow key make codes (extended set, E0 prefix ignored)

    localparam scan_code_t LEFT_CODE  = 8'h6B;
    localparam scan_code_t RIGHT_CODE = 8'h74;
    localparam scan_code_t UP_CODE    = 8'h75;
    localparam scan_code_t DOWN_CODE  = 8'h72;

endpackage

`default_nettype wire

/* verilog/ps2_receiver.sv */
`timescale 1ns/1ns
`default_nettype none

module ps2_receiver (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          ps2_clk,
    input  wire logic          ps2_data,
    output ps2_pkg::scan_code_t scan_code,
    output logic               key_valid
);
    import ps2_pkg::*;

    typedef enum logic [1:0] {
        idle,
        shift,
        check
    } state_t;

    localparam int COUNT_W = $clog2(FRAME_BITS);

    logic [FILTER_DEPTH-1:0] filter;
    logic                    clk_level;
    logic                    level_next;
    logic                    fall_edge;
    logic [1:0]              data_sync;
    state_t                  state;
    logic [COUNT_W-1:0]      bits_left;
    logic [FRAME_BITS-1:0]   frame;

    // --------------------
    // PS/2 clock filter

    // Bus idles high, so start the filter that way
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            filter    <= '1;
            clk_level <= 1'b1;
            data_sync <= 2'b11;
        end else begin
            filter    <= {ps2_clk, filter[FILTER_DEPTH-1:1]};
            clk_level <= level_next;
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    // Level only moves once every stage agrees
    always_comb begin
        level_next = clk_level;
        if (&filter) begin
            level_next = 1'b1;
        end else if (~|filter) begin
            level_next = 1'b0;
        end
    end

    assign fall_edge = clk_level & ~level_next;

    // --------------------
    // Frame assembly, LSB first

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= idle;
            bits_left <= '0;
            frame     <= '0;
        end else begin
            case (state)
                idle: begin
                    // Low data on a falling edge is a start bit
                    if (fall_edge && !data_sync[1]) begin
                        frame     <= {data_sync[1], frame[FRAME_BITS-1:1]};
                        bits_left <= COUNT_W'(FRAME_BITS - 2);
                        state     <= shift;
                    end
                end
                shift: begin
                    if (fall_edge) begin
                        frame     <= {data_sync[1], frame[FRAME_BITS-1:1]};
                        bits_left <= bits_left - 1'b1;
                        if (bits_left == '0) begin
                            state <= check;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Parity bit frame[9] is not checked
    assign key_valid = (state == check) && frame[FRAME_BITS-1];
    assign scan_code = scan_code_t'(frame[8:1]);

    // One strobe per frame since the FSM leaves check right away
    assert property (@(posedge clk) disable iff (reset) key_valid |=> !key_valid)
        else $error("key_valid high in two consecutive cycles");

endmodule

`default_nettype wire

/* verilog/cursor_control.sv */
`timescale 1ns/1ns
`default_nettype none

module cursor_control #(
    parameter int MOVE_DELAY = grid_pkg::MOVE_DELAY_DEFAULT
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                on,
    input  wire logic                draw,
    input  wire ps2_pkg::scan_code_t scan_code,
    input  wire logic                key_valid,
    output grid_pkg::coord_t         cursor_x,
    output grid_pkg::coord_t         cursor_y,
    output grid_pkg::cell_addr_t     write_addr,
    output logic                     write_en
);
    import grid_pkg::*;
    import ps2_pkg::*;

    typedef enum logic {
        init,
        run
    } state_t;

    state_t state;
    delay_t delay_count;

    // --------------------
    // Cursor movement

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= init;
            cursor_x    <= START_COORD;
            cursor_y    <= START_COORD;
            delay_count <= '0;
        end else if (on) begin
            case (state)
                init: begin
                    cursor_x <= START_COORD;
                    cursor_y <= START_COORD;
                    state    <= run;
                end
                default: begin
                    if (delay_count != '0) begin
                        delay_count <= delay_count - 1'b1;
                    end else if (key_valid) begin
                        // Moves off the edge are dropped and start no hold-off
                        case (scan_code)
                            RIGHT_CODE: begin
                                if (cursor_x < GRID_SIZE - 1) begin
                                    cursor_x    <= cursor_x + 1'b1;
                                    delay_count <= delay_t'(MOVE_DELAY);
                                end
                            end
                            LEFT_CODE: begin
                                if (cursor_x > 0) begin
                                    cursor_x    <= cursor_x - 1'b1;
                                    delay_count <= delay_t'(MOVE_DELAY);
                                end
                            end
                            UP_CODE: begin
                                if (cursor_y > 0) begin
                                    cursor_y    <= cursor_y - 1'b1;
                                    delay_count <= delay_t'(MOVE_DELAY);
                                end
                            end
                            DOWN_CODE: begin
                                if (cursor_y < GRID_SIZE - 1) begin
                                    cursor_y    <= cursor_y + 1'b1;
                                    delay_count <= delay_t'(MOVE_DELAY);
                                end
                            end
                            default: begin
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // --------------------
    // Pixel write port

    // Row-major index of the cell under the cursor
    assign write_addr = cell_addr_t'(cursor_y) * cell_addr_t'(GRID_SIZE)
                      + cell_addr_t'(cursor_x);
    assign write_en   = draw && on && (state == run);

    // Clamping keeps the cursor inside the grid the pixel store covers
    assert property (@(posedge clk) disable iff (reset)
        (cursor_x < GRID_SIZE) && (cursor_y < GRID_SIZE))
        else $error("cursor outside grid");

endmodule

`default_nettype wire

/* verilog/pixel_grid.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_grid (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire grid_pkg::cell_addr_t write_addr,
    input  wire logic                 write_en,
    input  wire grid_pkg::cell_addr_t read_addr,
    output logic                      pixel
);
    import grid_pkg::*;

    // One bit per cell, row-major
    logic [GRID_CELLS-1:0] pixels;

    // --------------------
    // Write port

    // Drawing only ever sets pixels, reset is the only way to erase
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pixels <= '0;
        end else if (write_en) begin
            pixels[write_addr] <= 1'b1;
        end
    end

    // --------------------
    // Registered read port

    // Addresses past the grid read as blank
    always_ff @(posedge clk) begin
        if (read_addr < GRID_CELLS) begin
            pixel <= pixels[read_addr];
        end else begin
            pixel <= 1'b0;
        end
    end

    // The cursor side must never address past the last cell
    assert property (@(posedge clk) disable iff (reset)
        write_en |-> (write_addr < GRID_CELLS))
        else $error("pixel write outside grid");

endmodule

`default_nettype wire

/* verilog/hex_display.sv */
`timescale 1ns/1ns
`default_nettype none

module hex_display (
    input  wire logic [3:0] digit,
    output logic      [6:0] segments
);

    // Active low, segment a in bit 0 through g in bit 6
    always_comb begin
        case (digit)
            4'h0: segments = 7'b1000000;
            4'h1: segments = 7'b1111001;
            4'h2: segments = 7'b0100100;
            4'h3: segments = 7'b0110000;
            4'h4: segments = 7'b0011001;
            4'h5: segments = 7'b0010010;
            4'h6: segments = 7'b0000010;
            4'h7: segments = 7'b1111000;
            4'h8: segments = 7'b0000000;
            4'h9: segments = 7'b0010000;
            // Letters, b and d in lower case
            4'hA: segments = 7'b0001000;
            4'hB: segments = 7'b0000011;
            4'hC: segments = 7'b1000110;
            4'hD: segments = 7'b0100001;
            4'hE: segments = 7'b0000110;
            default: segments = 7'b0001110;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/drawing_grid_top.sv */
`timescale 1ns/1ns
`default_nettype none

module drawing_grid_top #(
    parameter int MOVE_DELAY = grid_pkg::MOVE_DELAY_DEFAULT
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 on,
    input  wire logic                 draw,
    input  wire logic                 ps2_clk,
    input  wire logic                 ps2_data,
    input  wire grid_pkg::cell_addr_t read_addr,
    output logic                      pixel,
    output logic [6:0]                hex0,
    output logic [6:0]                hex1,
    output logic [6:0]                hex2,
    output logic [6:0]                hex3
);
    import grid_pkg::*;
    import ps2_pkg::*;

    scan_code_t key_code;
    logic       key_valid;
    coord_t     cursor_x;
    coord_t     cursor_y;
    cell_addr_t write_addr;
    logic       write_en;

    // --------------------
    // Keyboard to cursor to grid

    ps2_receiver i_ps2_receiver (
        .clk       (clk),
        .reset     (reset),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .scan_code (key_code),
        .key_valid (key_valid)
    );

    cursor_control #(
        .MOVE_DELAY (MOVE_DELAY)
    ) i_cursor_control (
        .clk        (clk),
        .reset      (reset),
        .on         (on),
        .draw       (draw),
        .scan_code  (key_code),
        .key_valid  (key_valid),
        .cursor_x   (cursor_x),
        .cursor_y   (cursor_y),
        .write_addr (write_addr),
        .write_en   (write_en)
    );

    pixel_grid i_pixel_grid (
        .clk        (clk),
        .reset      (reset),
        .write_addr (write_addr),
        .write_en   (write_en),
        .read_addr  (read_addr),
        .pixel      (pixel)
    );

    // --------------------
    // Cursor position in hex, x on hex1:hex0 and y on hex3:hex2

    hex_display i_hex0 (.digit(cursor_x[3:0]), .segments(hex0));
    hex_display i_hex1 (.digit({3'b000, cursor_x[4]}), .segments(hex1));
    hex_display i_hex2 (.digit(cursor_y[3:0]), .segments(hex2));
    hex_display i_hex3 (.digit({3'b000, cursor_y[4]}), .segments(hex3));

endmodule

`default_nettype wire

/* sim/tb_drawing_grid.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_drawing_grid;
    import grid_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int HALF_BIT    = 12;
    localparam int FRAME_GAP   = 100;
    localparam int POS_TIMEOUT = 200;

    logic       clk;
    logic       reset;
    logic       on;
    logic       draw;
    logic       ps2_clk;
    logic       ps2_data;
    cell_addr_t read_addr;
    logic       pixel;
    logic [6:0] hex0;
    logic [6:0] hex1;
    logic [6:0] hex2;
    logic [6:0] hex3;

    int           fd;
    int           status;
    int           ch;
    int           tests;
    int           errors;
    bit           done;
    logic [127:0] name;
    logic [63:0]  op;
    logic [31:0]  arg1;
    logic [31:0]  arg2;

    drawing_grid_top #(
        .MOVE_DELAY (20)
    ) i_drawing_grid_top (
        .clk       (clk),
        .reset     (reset),
        .on        (on),
        .draw      (draw),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .read_addr (read_addr),
        .pixel     (pixel),
        .hex0      (hex0),
        .hex1      (hex1),
        .hex2      (hex2),
        .hex3      (hex3)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------
    // Seven-segment readback

    // Active low, segment a in bit 0
    function automatic int segment_value(input logic [6:0] seg);
        case (seg)
            7'b1000000: return 0;
            7'b1111001: return 1;
            7'b0100100: return 2;
            7'b0110000: return 3;
            7'b0011001: return 4;
            7'b0010010: return 5;
            7'b0000010: return 6;
            7'b1111000: return 7;
            7'b0000000: return 8;
            7'b0010000: return 9;
            7'b0001000: return 10;
            7'b0000011: return 11;
            7'b1000110: return 12;
            7'b0100001: return 13;
            7'b0000110: return 14;
            7'b0001110: return 15;
            default: return -1;
        endcase
    endfunction

    // Unknown pattern on either digit gives -1
    function automatic int digit_pair(input logic [6:0] high, input logic [6:0] low);
        int hi_val;
        int lo_val;
        hi_val = segment_value(high);
        lo_val = segment_value(low);
        if (hi_val < 0 || lo_val < 0) begin
            return -1;
        end
        return hi_val * 16 + lo_val;
    endfunction

    // --------------------
    // Stimulus

    // Data changes while the PS/2 clock is high
    task automatic ps2_bit(input logic value);
        @(negedge clk);
        ps2_data = value;
        repeat (HALF_BIT) @(negedge clk);
        ps2_clk = 1'b0;
        repeat (HALF_BIT) @(negedge clk);
        ps2_clk = 1'b1;
    endtask

    task automatic send_frame(input logic [7:0] code, input logic stop);
        ps2_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            ps2_bit(code[i]);
        end
        // Odd parity
        ps2_bit(~^code);
        ps2_bit(stop);
        ps2_data = 1'b1;
        repeat (FRAME_GAP) @(negedge clk);
    endtask

    task automatic draw_pulse(input int cycles);
        @(negedge clk);
        draw = 1'b1;
        repeat (cycles) @(negedge clk);
        draw = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic set_on(input logic level);
        @(negedge clk);
        on = level;
        repeat (2) @(negedge clk);
    endtask

    // --------------------
    // Checks

    task automatic check_position(input logic [127:0] test, input int x_exp, input int y_exp);
        int x_act;
        int y_act;
        int waited;
        waited = 0;
        x_act = digit_pair(hex1, hex0);
        y_act = digit_pair(hex3, hex2);
        while ((x_act != x_exp || y_act != y_exp) && waited < POS_TIMEOUT) begin
            @(negedge clk);
            waited++;
            x_act = digit_pair(hex1, hex0);
            y_act = digit_pair(hex3, hex2);
        end
        tests++;
        if (x_act != x_exp || y_act != y_exp) begin
            errors++;
            $display("ERROR %0s: expected x=%0d y=%0d, actual x=%0d y=%0d after %0d-cycle timeout",
                     test, x_exp, y_exp, x_act, y_act, POS_TIMEOUT);
        end else begin
            $display("pass  %0s: x=%0d y=%0d", test, x_act, y_act);
        end
    endtask

    // Registered read, so sample one edge later
    task automatic check_pixel(input logic [127:0] test, input cell_addr_t addr,
                               input logic expected);
        @(negedge clk);
        read_addr = addr;
        @(negedge clk);
        tests++;
        if (pixel !== expected) begin
            errors++;
            $display("ERROR %0s: addr %0d expected %0b, actual %0b", test, addr, expected, pixel);
        end else begin
            $display("pass  %0s: addr %0d = %0b", test, addr, pixel);
        end
    endtask

    task automatic run_step(input logic [127:0] test, input logic [63:0] kind,
                            input logic [31:0] a, input logic [31:0] b);
        if (kind == "key") begin
            for (int n = 0; n < b; n++) begin
                send_frame(a[7:0], 1'b1);
            end
        end else if (kind == "badkey") begin
            send_frame(a[7:0], 1'b0);
        end else if (kind == "draw") begin
            draw_pulse(a);
        end else if (kind == "on") begin
            set_on(a[0]);
        end else if (kind == "read") begin
            check_pixel(test, cell_addr_t'(a), b[0]);
        end else if (kind == "pos") begin
            check_position(test, a, b);
        end else begin
            errors++;
            $display("%0s: unknown operation %0s in the vector file", test, kind);
        end
    endtask

    // --------------------
    // Main sequence

    initial begin
        reset     = 1'b1;
        on        = 1'b1;
        draw      = 1'b0;
        ps2_clk   = 1'b1;
        ps2_data  = 1'b1;
        read_addr = '0;
        tests     = 0;
        errors    = 0;
        done      = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        fd = $fopen("sim/drawing_grid_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open sim/drawing_grid_vectors.txt");
        end else begin
            while (!done) begin
                status = $fscanf(fd, "%s", name);
                if (status != 1) begin
                    done = 1'b1;
                end else if (name == "#") begin
                    // Skip the rest of a comment line
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    status = $fscanf(fd, "%s %h %h", op, arg1, arg2);
                    if (status != 3) begin
                        errors++;
                        $display("vector line for %0s is incomplete", name);
                        done = 1'b1;
                    end else begin
                        run_step(name, op, arg1, arg2);
                    end
                end
            end
            $fclose(fd);
        end

        $display("%0d checks run, %0d failed", tests, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/drawing_grid_vectors.txt */
# Columns: test name, operation, arg1, arg2 (both arguments in hex)
# key: code, repeat count | badkey: code, 0 | draw: cycles, 0 | on: level, 0 | read: addr, pixel | pos: x, y
reset_pos      pos    0e  0e
reset_read_a   read   000 0
reset_read_b   read   196 0
reset_read_c   read   30f 0
move_right     key    74  1
right_pos      pos    0f  0e
move_left      key    6b  1
left_pos       pos    0e  0e
move_up        key    75  1
up_pos         pos    0e  0d
move_down      key    72  1
down_pos       pos    0e  0e
clamp_left     key    6b  10
clamp_up       key    75  10
clamp_min_pos  pos    00  00
draw_corner    draw   3   0
corner_set     read   000 1
corner_next    read   001 0
clamp_right    key    74  1e
clamp_down     key    72  1e
clamp_max_pos  pos    1b  1b
draw_far       draw   3   0
far_set        read   30f 1
far_next       read   30e 0
back_left      key    6b  0d
back_up        key    75  0d
centre_pos     pos    0e  0e
bad_stop       badkey 74  0
bad_stop_pos   pos    0e  0e
non_arrow      key    1c  1
non_arrow_pos  pos    0e  0e
turn_off       on     0   0
off_key        key    74  1
off_key_pos    pos    0e  0e
off_draw       draw   3   0
turn_on        on     1   0
off_draw_read  read   196 0
draw_centre    draw   3   0
centre_set     read   196 1
centre_right   read   197 0
centre_above   read   17a 0

/* filelist.f */
verilog/grid_pkg.sv
verilog/ps2_pkg.sv
verilog/ps2_receiver.sv
verilog/cursor_control.sv
verilog/pixel_grid.sv
verilog/hex_display.sv
verilog/drawing_grid_top.sv
sim/tb_drawing_grid.sv

/* Bender.yml */
package:
  name: drawing_grid

sources:
  - verilog/grid_pkg.sv
  - verilog/ps2_pkg.sv
  - verilog/ps2_receiver.sv
  - verilog/cursor_control.sv
  - verilog/pixel_grid.sv
  - verilog/hex_display.sv
  - verilog/drawing_grid_top.sv
  - target: simulation
    files:
      - sim/tb_drawing_grid.sv
